// File: source/vmul_macros.svh
`ifndef VMUL_MACROS_SVH
`define VMUL_MACROS_SVH

// element width in bits
`define VMUL_WIDTH 16

// bits of the fixed-point shift amount, covers 0 to width-1
`define VMUL_LOG2WIDTH 4

// elements carried by one vector instruction
`define VMUL_NUM_LANES 8

// physical multipliers, must divide the lane count
`define VMUL_NUM_MUL_LANES 2

// destination register id width
`define VMUL_REGID_WIDTH 5

// multiplier passes needed for one instruction
`define VMUL_NUM_PASSES (`VMUL_NUM_LANES / `VMUL_NUM_MUL_LANES)

`endif

// File: source/vmul_pkg.sv
`default_nettype none

`include "vmul_macros.svh"

package vmul_pkg;

  // multiply flavours
  // low product is the same for signed and unsigned operands
  typedef enum logic [1:0] {
    VMUL_LO   = 2'd0,
    VMUL_HI_S = 2'd1,
    VMUL_HI_U = 2'd2,
    VMUL_FX   = 2'd3
  } vmul_op_t;

  // one vector element
  typedef logic [`VMUL_WIDTH-1:0] elem_t;

  // operand pair for one lane, streamed through the operand shifter
  typedef struct packed {
    elem_t a;
    elem_t b;
  } opnd_pair_t;

  // one group of pairs, as seen by the multiplier bank
  typedef opnd_pair_t [`VMUL_NUM_MUL_LANES-1:0] opnd_group_t;

  // instruction as issued
  typedef struct packed {
    vmul_op_t                     op;
    // arithmetic right shift applied by VMUL_FX only
    logic [`VMUL_LOG2WIDTH-1:0]   shamt;
    logic [`VMUL_REGID_WIDTH-1:0] dst;
    logic                         dst_we;
    // one bit per lane, passed through to writeback
    logic [`VMUL_NUM_LANES-1:0]   mask;
  } vmul_instr_t;

  // writeback bundle
  // data[i] belongs to lane i
  typedef struct packed {
    logic [`VMUL_REGID_WIDTH-1:0]      dst;
    logic                              we;
    logic [`VMUL_NUM_LANES-1:0]        mask;
    elem_t [`VMUL_NUM_LANES-1:0]       data;
  } vmul_wb_t;

endpackage

`default_nettype wire

// File: source/vmul_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

`include "vmul_macros.svh"

module vmul_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         activate,
  input  vmul_pkg::vmul_instr_t        instr,
  input  logic                         squash,
  output logic                         stall,
  output logic                         load,
  output logic                         first,
  output logic                         busy,
  output vmul_pkg::vmul_op_t           lane_op,
  output logic [`VMUL_LOG2WIDTH-1:0]   lane_shamt,
  output vmul_pkg::vmul_wb_t           wb_tag
);

  import vmul_pkg::*;

  localparam int NUM_PASSES = `VMUL_NUM_PASSES;
  localparam int CNT_W = (NUM_PASSES > 1) ? $clog2(NUM_PASSES) : 1;
  // one stage per pass plus the lane register
  localparam int TAG_DEPTH = NUM_PASSES + 1;
  localparam logic [CNT_W-1:0] LAST_PASS = CNT_W'(NUM_PASSES - 1);

  // destination tag carried beside the data
  typedef struct packed {
    logic [`VMUL_REGID_WIDTH-1:0] dst;
    logic                         we;
    logic [`VMUL_NUM_LANES-1:0]   mask;
  } tag_t;

  logic                       accept;
  logic                       mask_empty;
  logic                       active_q;
  logic                       first_q;
  logic [CNT_W-1:0]           pass_q;
  vmul_op_t                   op_q;
  logic [`VMUL_LOG2WIDTH-1:0] shamt_q;
  tag_t                       entry_tag;
  tag_t [TAG_DEPTH:1]         tag_q;

  // kill the write enable of a tag moving down the line
  function automatic tag_t squash_tag(tag_t t, logic kill);
    tag_t r;
    r = t;
    r.we = t.we & ~kill;
    return r;
  endfunction

  assign mask_empty = ~|instr.mask;

  // stall holds issue until the last group is in the multipliers
  assign stall  = active_q && (pass_q != LAST_PASS);
  assign accept = activate && !stall;

  assign load  = accept;
  // group 0 comes straight from the operand ports
  assign first = first_q;
  // lanes and both shifters advance for every pass
  assign busy  = active_q;

  // pass counter
  // an empty mask starts at the last pass so no stall is raised
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      active_q <= 1'b0;
      first_q  <= 1'b0;
      pass_q   <= '0;
    end
    else
    begin
      first_q <= accept;
      if (accept)
      begin
        active_q <= 1'b1;
        pass_q   <= mask_empty ? LAST_PASS : '0;
      end
      else if (active_q)
      begin
        if (pass_q == LAST_PASS)
          active_q <= 1'b0;
        else
          pass_q <= pass_q + 1'b1;
      end
    end
  end

  // op and shift amount of the instruction in the multipliers
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q    <= instr.op;
      shamt_q <= instr.shamt;
    end
  end

  assign lane_op    = op_q;
  assign lane_shamt = shamt_q;

  assign entry_tag.dst  = instr.dst;
  assign entry_tag.we   = accept & instr.dst_we;
  assign entry_tag.mask = instr.mask;

  // tag delay line
  // empty-mask tags enter near the end and leave one cycle later
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      tag_q <= '0;
    else
    begin
      tag_q[1]    <= entry_tag;
      tag_q[1].we <= entry_tag.we & ~mask_empty;
      for (int k = 2; k <= TAG_DEPTH; k++)
        tag_q[k] <= squash_tag(tag_q[k-1], squash);
      if (accept && mask_empty)
        tag_q[NUM_PASSES] <= entry_tag;
    end
  end

  assign wb_tag.dst  = tag_q[TAG_DEPTH].dst;
  assign wb_tag.we   = tag_q[TAG_DEPTH].we;
  assign wb_tag.mask = tag_q[TAG_DEPTH].mask;
  // result data is merged in at the top level
  assign wb_tag.data = '0;

endmodule

`default_nettype wire

// File: source/velmshifter.sv
`default_nettype none
`timescale 1ns/100ps

// chain of element groups
// group 0 sits at the low end of par_in and par_out
module velmshifter #(
  parameter int  NUM_GROUPS = 4,
  parameter int  GROUP_SIZE = 2,
  parameter type elem_type  = logic
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  load,
  input  logic                                  shift,
  input  elem_type [GROUP_SIZE-1:0]             shift_in,
  input  elem_type [NUM_GROUPS*GROUP_SIZE-1:0]  par_in,
  output elem_type [NUM_GROUPS*GROUP_SIZE-1:0]  par_out
);

  // one row per group
  elem_type [NUM_GROUPS-1:0][GROUP_SIZE-1:0] grp_q;

  // load wins over shift
  // a shift moves every group one step toward group 0
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      grp_q <= '0;
    else if (load)
      grp_q <= par_in;
    else if (shift)
    begin
      for (int g = 0; g < NUM_GROUPS - 1; g++)
        grp_q[g] <= grp_q[g+1];
      // new group enters at the top
      grp_q[NUM_GROUPS-1] <= shift_in;
    end
  end

  assign par_out = grp_q;

endmodule

`default_nettype wire

// File: source/vlane_mulshift.sv
`default_nettype none
`timescale 1ns/100ps

`include "vmul_macros.svh"

module vlane_mulshift (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        en,
  input  vmul_pkg::elem_t             a,
  input  vmul_pkg::elem_t             b,
  input  vmul_pkg::vmul_op_t          op,
  input  logic [`VMUL_LOG2WIDTH-1:0]  shamt,
  output vmul_pkg::elem_t             result
);

  import vmul_pkg::*;

  localparam int W = `VMUL_WIDTH;

  logic                       is_signed;
  logic signed [W:0]          a_ext;
  logic signed [W:0]          b_ext;
  logic signed [2*W+1:0]      prod_full;
  logic [2*W-1:0]             prod_q;
  vmul_op_t                   op_q;
  logic [`VMUL_LOG2WIDTH-1:0] shamt_q;
  logic signed [2*W-1:0]      fx_shifted;

  // only the unsigned high product treats operands as unsigned
  assign is_signed = (op != VMUL_HI_U);

  // one extra bit turns both cases into a signed multiply
  assign a_ext = {is_signed & a[W-1], a};
  assign b_ext = {is_signed & b[W-1], b};
  assign prod_full = a_ext * b_ext;

  // the true product always fits in 2W bits
  always_ff @(posedge clk)
  begin
    if (en)
      prod_q <= prod_full[2*W-1:0];
  end

  // op and shift amount follow the product into the register stage
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      op_q    <= VMUL_LO;
      shamt_q <= '0;
    end
    else if (en)
    begin
      op_q    <= op;
      shamt_q <= shamt;
    end
  end

  assign fx_shifted = $signed(prod_q) >>> shamt_q;

  // result selection after the register
  always_comb
  begin
    case (op_q)
      VMUL_LO:   result = prod_q[W-1:0];
      VMUL_HI_S: result = prod_q[2*W-1:W];
      VMUL_HI_U: result = prod_q[2*W-1:W];
      VMUL_FX:   result = fx_shifted[W-1:0];
      default:   result = prod_q[W-1:0];
    endcase
  end

endmodule

`default_nettype wire

// File: source/vmul_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "vmul_macros.svh"

module vmul_unit (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     activate,
  input  vmul_pkg::vmul_instr_t                    instr,
  input  vmul_pkg::elem_t [`VMUL_NUM_LANES-1:0]    opa,
  input  vmul_pkg::elem_t [`VMUL_NUM_LANES-1:0]    opb,
  input  logic                                     squash,
  output logic                                     stall,
  output vmul_pkg::vmul_wb_t                       wb
);

  import vmul_pkg::*;

  localparam int NUM_LANES  = `VMUL_NUM_LANES;
  localparam int NUM_MUL    = `VMUL_NUM_MUL_LANES;
  localparam int NUM_PASSES = `VMUL_NUM_PASSES;

  logic                                load;
  logic                                first;
  logic                                busy;
  vmul_op_t                            lane_op;
  logic [`VMUL_LOG2WIDTH-1:0]          lane_shamt;
  vmul_wb_t                            wb_tag;
  opnd_pair_t [NUM_LANES-1:0]          opnd_pairs;
  opnd_pair_t [NUM_LANES-1:0]          opnd_buf;
  opnd_group_t                         mul_group;
  elem_t [NUM_MUL-1:0]                 lane_result;
  elem_t [NUM_LANES-NUM_MUL-1:0]       result_buf;

  // pair up operands lane by lane
  always_comb
  begin
    for (int i = 0; i < NUM_LANES; i++)
    begin
      opnd_pairs[i].a = opa[i];
      opnd_pairs[i].b = opb[i];
    end
  end

  vmul_ctrl vmul_ctrl_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .activate   (activate),
    .instr      (instr),
    .squash     (squash),
    .stall      (stall),
    .load       (load),
    .first      (first),
    .busy       (busy),
    .lane_op    (lane_op),
    .lane_shamt (lane_shamt),
    .wb_tag     (wb_tag)
  );

  // holds the groups still waiting for a multiplier
  velmshifter #(
    .NUM_GROUPS (NUM_PASSES),
    .GROUP_SIZE (NUM_MUL),
    .elem_type  (opnd_pair_t)
  ) opnd_shifter (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (load),
    .shift    (busy),
    .shift_in ('0),
    .par_in   (opnd_pairs),
    .par_out  (opnd_buf)
  );

  // group 0 straight from the ports, later groups from the bottom of the shifter
  assign mul_group = first ? opnd_pairs[NUM_MUL-1:0] : opnd_buf[NUM_MUL-1:0];

  for (genvar k = 0; k < NUM_MUL; k++)
  begin : gen_lane
    vlane_mulshift vlane_mulshift_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .en     (busy),
      .a      (mul_group[k].a),
      .b      (mul_group[k].b),
      .op     (lane_op),
      .shamt  (lane_shamt),
      .result (lane_result[k])
    );
  end

  // finished groups enter at the top and sink toward group 0
  // the last group never enters, it is taken from the lane outputs
  velmshifter #(
    .NUM_GROUPS (NUM_PASSES - 1),
    .GROUP_SIZE (NUM_MUL),
    .elem_type  (elem_t)
  ) result_shifter (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (1'b0),
    .shift    (busy),
    .shift_in (lane_result),
    .par_in   ('0),
    .par_out  (result_buf)
  );

  // at writeback groups 0 to P-2 sit in the result shifter
  // and the last group is still on the lane outputs
  always_comb
  begin
    wb.dst  = wb_tag.dst;
    wb.we   = wb_tag.we;
    wb.mask = wb_tag.mask;
    for (int i = 0; i < NUM_LANES - NUM_MUL; i++)
      wb.data[i] = result_buf[i];
    for (int k = 0; k < NUM_MUL; k++)
      wb.data[NUM_LANES-NUM_MUL+k] = lane_result[k];
  end

endmodule

`default_nettype wire

// File: test/tb_vmul_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "vmul_macros.svh"

module tb_vmul_unit;

  import vmul_pkg::*;

  localparam int P       = `VMUL_NUM_PASSES;
  localparam int LANES   = `VMUL_NUM_LANES;
  localparam int TIMEOUT = 100;

  // one expected writeback, due on a given sampling cycle
  typedef struct packed {
    logic [31:0]                  due;
    logic                         we;
    logic [`VMUL_REGID_WIDTH-1:0] dst;
    logic [LANES-1:0]             mask;
    elem_t [LANES-1:0]            data;
  } exp_wb_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   activate;
  vmul_instr_t            instr;
  elem_t [LANES-1:0]      opa;
  elem_t [LANES-1:0]      opb;
  logic                   squash;
  logic                   stall;
  vmul_wb_t               wb;

  logic [31:0] lcg_state = 32'h5957beb9;
  logic [31:0] cyc;
  int          stall_left;
  logic [31:0] last_acc_cyc;
  logic        last_acc_valid;
  logic        last_nonzero;
  logic        held;
  int          err_count = 0;
  string       test_name = "reset";
  exp_wb_t     exp_q[$];

  vmul_unit vmul_unit_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .activate (activate),
    .instr    (instr),
    .opa      (opa),
    .opb      (opb),
    .squash   (squash),
    .stall    (stall),
    .wb       (wb)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // result rules, worked out on 64-bit integers
  function automatic elem_t ref_mul(vmul_op_t op, logic [`VMUL_LOG2WIDTH-1:0] shamt,
                                    elem_t a, elem_t b);
    longint          sp;
    longint unsigned up;
    elem_t           r;
    sp = longint'($signed(a)) * longint'($signed(b));
    up = {48'b0, a} * {48'b0, b};
    case (op)
      VMUL_LO:   r = up[15:0];
      VMUL_HI_S: r = sp[31:16];
      VMUL_HI_U: r = up[31:16];
      default:   r = elem_t'(sp >>> shamt);
    endcase
    return r;
  endfunction

  task automatic report_mismatch(string what, logic [63:0] exp, logic [63:0] act);
    err_count++;
    $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, exp, act);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(string msg);
    err_count++;
    $display("%s during %s", msg, test_name);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // checks every sampling edge against the bookkeeping
  always @(posedge clk)
  begin
    exp_wb_t e;
    logic    accept;
    if (!rst_n)
    begin
      cyc = 0;
      stall_left = 0;
      last_acc_valid = 1'b0;
      held = 1'b0;
      exp_q.delete();
    end
    else
    begin
      cyc++;
      accept = activate && !stall;
      if (!activate)
        held = 1'b0;
      assert (stall === (stall_left != 0))
      else report_mismatch("stall", 64'(stall_left != 0), 64'(stall));
      if (stall_left != 0)
        stall_left--;
      if (exp_q.size() != 0 && exp_q[0].due == cyc)
      begin
        e = exp_q.pop_front();
        assert (wb.we === e.we) else report_mismatch("wb.we", 64'(e.we), 64'(wb.we));
        assert (wb.dst === e.dst) else report_mismatch("wb.dst", 64'(e.dst), 64'(wb.dst));
        assert (wb.mask === e.mask) else report_mismatch("wb.mask", 64'(e.mask), 64'(wb.mask));
        // data is only defined when some lane is enabled
        if (e.mask != 0)
        begin
          for (int i = 0; i < LANES; i++)
            assert (wb.data[i] === e.data[i])
            else report_mismatch($sformatf("wb.data[%0d]", i), 64'(e.data[i]), 64'(wb.data[i]));
        end
      end
      else
        assert (wb.we === 1'b0) else report_mismatch("idle wb.we", 64'(0), 64'(wb.we));
      // squash hits every tag still in flight
      if (squash)
        foreach (exp_q[j])
          exp_q[j].we = 1'b0;
      if (accept)
      begin
        if (last_acc_valid && held)
          assert (cyc - last_acc_cyc == (last_nonzero ? P : 1))
          else report_mismatch("issue gap", 64'(last_nonzero ? P : 1),
                               64'(cyc - last_acc_cyc));
        e.due  = cyc + ((instr.mask == 0) ? 2 : P + 1);
        e.we   = instr.dst_we;
        e.dst  = instr.dst;
        e.mask = instr.mask;
        for (int i = 0; i < LANES; i++)
          e.data[i] = ref_mul(instr.op, instr.shamt, opa[i], opb[i]);
        exp_q.push_back(e);
        if (instr.mask != 0)
          stall_left = P - 1;
        last_acc_cyc = cyc;
        last_acc_valid = 1'b1;
        last_nonzero = (instr.mask != 0);
        held = 1'b1;
      end
    end
  end

  // shift amounts 0 and width-1 come up regularly
  function automatic vmul_instr_t random_instr(int idx, bit empty);
    vmul_instr_t ins;
    logic [31:0] r;
    r = lcg_next();
    ins.op = vmul_op_t'(idx % 4);
    if (idx % 5 == 0)
      ins.shamt = '0;
    else if (idx % 5 == 1)
      ins.shamt = (`VMUL_LOG2WIDTH)'(`VMUL_WIDTH - 1);
    else
      ins.shamt = r[3:0];
    ins.dst = r[12:8];
    ins.dst_we = (r[20:18] != 3'd0);
    ins.mask = empty ? '0 : r[31:24];
    if (!empty && ins.mask == 0)
      ins.mask = 8'h01;
    return ins;
  endfunction

  // present an instruction and wait for its acceptance edge
  // while stall is high the unit still reads the previous operands
  task automatic issue(input vmul_instr_t ins);
    logic        got;
    logic [31:0] r;
    int          n;
    n = 0;
    while (stall)
    begin
      @(posedge clk);
      #0.5;
      n++;
      if (n > TIMEOUT)
        abort_run("stall never dropped");
    end
    instr = ins;
    for (int i = 0; i < LANES; i++)
    begin
      r = lcg_next();
      opa[i] = r[31:16];
      r = lcg_next();
      opb[i] = r[31:16];
    end
    activate = 1'b1;
    got = 1'b0;
    n = 0;
    while (!got)
    begin
      @(posedge clk);
      got = activate && !stall;
      #0.5;
      n++;
      if (n > TIMEOUT)
        abort_run("instruction was never accepted");
    end
  endtask

  task automatic idle(input int cycles);
    activate = 1'b0;
    repeat (cycles)
    begin
      @(posedge clk);
      #0.5;
    end
  endtask

  // squash lands on the k-th sampling edge after acceptance
  task automatic issue_squashed(input vmul_instr_t ins, input int k);
    issue(ins);
    activate = 1'b0;
    repeat (k - 1)
    begin
      @(posedge clk);
      #0.5;
    end
    squash = 1'b1;
    @(posedge clk);
    #0.5;
    squash = 1'b0;
  endtask

  initial
  begin
    int          n;
    vmul_instr_t ins;
    rst_n = 1'b0;
    activate = 1'b0;
    instr = '0;
    opa = '0;
    opb = '0;
    squash = 1'b0;
    repeat (10) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    idle(6);

    test_name = "arithmetic";
    for (int i = 0; i < 24; i++)
    begin
      issue(random_instr(i, 1'b0));
      idle(6);
    end

    // activate stays high across the whole run
    test_name = "back_to_back";
    for (int i = 0; i < 16; i++)
      issue(random_instr(i + 3, 1'b0));
    idle(8);

    test_name = "empty_mask";
    issue(random_instr(0, 1'b1));
    issue(random_instr(1, 1'b1));
    issue(random_instr(2, 1'b0));
    issue(random_instr(3, 1'b1));
    issue(random_instr(4, 1'b0));
    idle(8);

    // both instructions write, so a lost or leaked squash shows on wb.we
    test_name = "squash";
    for (int k = 1; k <= P; k++)
    begin
      ins = random_instr(k, 1'b0);
      ins.dst_we = 1'b1;
      issue_squashed(ins, k);
      ins = random_instr(k + 7, 1'b0);
      ins.dst_we = 1'b1;
      issue(ins);
      idle(8);
    end

    test_name = "drain";
    n = 0;
    while (exp_q.size() != 0)
    begin
      @(posedge clk);
      #0.5;
      n++;
      if (n > TIMEOUT)
        abort_run("expected writebacks never arrived");
    end
    idle(4);

    if (err_count == 0)
    begin
      $display("TB PASSED");
      $finish;
    end
    else
    begin
      $display("TB FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+source
source/vmul_pkg.sv
source/vmul_ctrl.sv
source/velmshifter.sv
source/vlane_mulshift.sv
source/vmul_unit.sv
test/tb_vmul_unit.sv

// File: Makefile
# Verilator build and run for the vector multiply unit
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_vmul_unit
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TB PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
